//--- hw/bus_master.sv
//####################################################################
// bus_master: line read and write-back requests on the memory bus
// eight-beat write-back send and eight-beat refill collect
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module bus_master (
  input wire clk,
  input wire reset,
  input wire fetch_start,
  input wire cache_pkg::cache_addr_t fetch_addr,
  input wire wb_start,
  input wire cache_pkg::cache_addr_t wb_addr,
  input wire cache_pkg::line_t wb_line,
  output cache_pkg::line_t refill_line,
  output logic refill_done,
  output logic writeback_done,
  output logic bus_reqcyc,
  input wire bus_reqack,
  output logic [bus_pkg::bus_data_width-1:0] bus_req,
  output logic [bus_pkg::bus_tag_width-1:0] bus_reqtag,
  input wire bus_respcyc,
  output logic bus_respack,
  input wire [bus_pkg::bus_data_width-1:0] bus_resp,
  input wire [bus_pkg::bus_tag_width-1:0] bus_resptag
);

  localparam logic [3:0] last_cnt = 4'(cache_pkg::beats_per_line);

  logic sending;
  logic [3:0] wb_cnt;
  logic [3:0] rf_cnt;
  logic wb_acked;
  logic wb_last;
  logic rf_full;
  logic beat_in;

  // write-back header accepted, data beats follow right away
  assign wb_acked = bus_reqcyc && bus_reqack && (bus_reqtag == bus_pkg::mem_write_tag);
  assign wb_last = (wb_cnt == last_cnt);
  assign rf_full = (rf_cnt == last_cnt);
  // a beat not yet acknowledged, respack low means it is new
  assign beat_in = bus_respcyc && !bus_respack && !rf_full &&
                   (bus_resptag == bus_pkg::mem_read_tag);

  // request strobe and write-back beat sequencing
  always_ff @(posedge clk) begin
    if (!reset) begin
      bus_reqcyc <= 1'b0;
      sending <= 1'b0;
      wb_cnt <= '0;
      writeback_done <= 1'b0;
    end else begin
      writeback_done <= 1'b0;
      if (wb_start || fetch_start) begin
        bus_reqcyc <= 1'b1;
      end else if (bus_reqcyc && bus_reqack) begin
        bus_reqcyc <= 1'b0;
        // word 0 goes out on the ack edge
        sending <= wb_acked;
        wb_cnt <= 4'd1;
      end else if (sending) begin
        if (wb_last) begin
          sending <= 1'b0;
          writeback_done <= 1'b1;
        end else begin
          wb_cnt <= wb_cnt + 4'd1;
        end
      end
    end
  end

  // address, tag and data beats share bus_req
  always_ff @(posedge clk) begin
    if (wb_start) begin
      bus_req <= {wb_addr.tag, wb_addr.index, {cache_pkg::offset_bits{1'b0}}};
      bus_reqtag <= bus_pkg::mem_write_tag;
    end else if (fetch_start) begin
      bus_req <= {fetch_addr.tag, fetch_addr.index, {cache_pkg::offset_bits{1'b0}}};
      bus_reqtag <= bus_pkg::mem_read_tag;
    end else if (wb_acked) begin
      bus_req <= wb_line[0];
    end else if (sending && !wb_last) begin
      bus_req <= wb_line[wb_cnt[2:0]];
    end
  end

  // refill side: count beats, ack each one for a single cycle
  always_ff @(posedge clk) begin
    if (!reset) begin
      bus_respack <= 1'b0;
      rf_cnt <= '0;
      refill_done <= 1'b0;
    end else begin
      bus_respack <= beat_in;
      refill_done <= 1'b0;
      if (fetch_start) begin
        rf_cnt <= '0;
      end else if (rf_full) begin
        rf_cnt <= '0;
        refill_done <= 1'b1;
      end else if (beat_in) begin
        rf_cnt <= rf_cnt + 4'd1;
      end
    end
  end

  // line buffer, lowest word arrives first
  always_ff @(posedge clk) begin
    if (beat_in) begin
      refill_line[rf_cnt[2:0]] <= bus_resp;
    end
  end

  // the memory may sample the request on any cycle until it acks
  req_held: assert property (
    @(posedge clk) disable iff (!reset)
    bus_reqcyc && !bus_reqack |=> $stable(bus_req) && $stable(bus_reqtag)
  );

endmodule

`default_nettype wire

//--- hw/bus_pkg.sv
//####################################################################
// memory bus widths and request tags
// core memory-operation encoding
//####################################################################
`default_nettype none

package bus_pkg;

  localparam int bus_data_width = 64;
  localparam int bus_tag_width = 13;

  // read asks for a line, write announces a victim line
  localparam logic [bus_tag_width-1:0] mem_read_tag = 13'h1100;
  localparam logic [bus_tag_width-1:0] mem_write_tag = 13'h0100;

  typedef logic [bus_data_width-1:0] mem_word_t;

  // loads first, stores after
  typedef enum logic [3:0] {
    ld, lw, lh, lb,
    lwu, lhu, lbu,
    sd, sw, sh, sb
  } mem_op_t;

endpackage

`default_nettype wire

//--- hw/cache_ctrl.sv
//####################################################################
// cache_ctrl: hit detection and victim choice
// access FSM, array write control, bus transfer starts
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input wire clk,
  input wire reset,
  input wire access,
  input wire write,
  input wire cache_pkg::cache_addr_t address,
  input wire bus_pkg::mem_op_t mem_type,
  input wire cache_pkg::tag_entry_t [cache_pkg::ways-1:0] tag_rd,
  output logic tag_wr_en,
  output logic data_wr_en,
  output cache_pkg::way_sel_t wr_way,
  output cache_pkg::tag_entry_t tag_wr_entry,
  output logic data_sel_merge,
  output logic fetch_start,
  output logic wb_start,
  output cache_pkg::cache_addr_t wb_addr,
  input wire refill_done,
  input wire writeback_done,
  output logic busy,
  output logic finished
);

  typedef enum logic [2:0] {
    idle, lookup, writeback, refill, fill, done
  } state_t;

  state_t state;
  logic store;
  logic hit;
  logic found_invalid;
  logic victim_dirty;
  logic miss;
  cache_pkg::way_sel_t hit_way;
  cache_pkg::way_sel_t victim;
  cache_pkg::way_sel_t way_r;
  logic [7:0] lfsr;

  // only store encodings change the line
  assign store = write &&
                 (mem_type inside {bus_pkg::sd, bus_pkg::sw, bus_pkg::sh, bus_pkg::sb});

  // tag compare over the set, victim is first invalid way, else random
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    found_invalid = 1'b0;
    victim = lfsr[1:0];
    for (int w = 0; w < cache_pkg::ways; w++) begin
      if (tag_rd[w].valid && tag_rd[w].tag == address.tag) begin
        hit = 1'b1;
        hit_way = cache_pkg::way_sel_t'(w);
      end
      if (!tag_rd[w].valid && !found_invalid) begin
        found_invalid = 1'b1;
        victim = cache_pkg::way_sel_t'(w);
      end
    end
  end

  assign victim_dirty = tag_rd[victim].valid && tag_rd[victim].dirty;
  assign miss = (state == lookup) && !hit;
  assign wb_addr = {tag_rd[victim].tag, address.index, {cache_pkg::offset_bits{1'b0}}};

  // bus transfers start on the edge that leaves lookup or writeback
  assign wb_start = miss && victim_dirty;
  assign fetch_start = (miss && !victim_dirty) || (state == writeback && writeback_done);

  // store hit merges and sets dirty, fill installs the clean line
  assign tag_wr_en = (state == lookup && hit && store) || (state == fill);
  assign data_wr_en = tag_wr_en;
  assign tag_wr_entry = {1'b1, state == lookup, address.tag};
  assign wr_way = (state == lookup) ? hit_way : way_r;
  // refill buffer feeds the arrays and the aligner only during fill
  assign data_sel_merge = (state != fill);

  // a load miss returns straight from the refill buffer
  assign finished = (state == done) || (state == fill && !store);
  assign busy = access && !finished;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= idle;
      lfsr <= 8'h01;
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1, free running
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      case (state)
        idle: begin
          if (access) begin
            state <= lookup;
          end
        end
        lookup: begin
          if (hit) begin
            state <= done;
          end else if (victim_dirty) begin
            state <= writeback;
          end else begin
            state <= refill;
          end
        end
        writeback: begin
          if (writeback_done) begin
            state <= refill;
          end
        end
        refill: begin
          if (refill_done) begin
            state <= fill;
          end
        end
        // store goes back through lookup and now hits
        fill: state <= store ? lookup : idle;
        default: state <= idle;
      endcase
    end
  end

  // way held for write-back read, fill and the done response
  always_ff @(posedge clk) begin
    if (state == lookup) begin
      way_r <= hit ? hit_way : victim;
    end
  end

  single_finish: assert property (
    @(posedge clk) disable iff (!reset) finished |=> !finished
  );

endmodule

`default_nettype wire

//--- hw/cache_pkg.sv
//####################################################################
// cache geometry, address field widths
// address split, line type and tag entry type
//####################################################################
`default_nettype none

package cache_pkg;

  // 8 KB total, 4 ways x 32 sets x 64 byte lines
  localparam int ways = 4;
  localparam int sets = 32;
  localparam int line_bytes = 64;
  // 64-bit words per line, also the beat count on the bus
  localparam int beats_per_line = line_bytes / 8;

  // address fields, tag takes whatever is left of 64 bits
  localparam int offset_bits = 6;
  localparam int index_bits = 5;
  localparam int tag_bits = 64 - index_bits - offset_bits;

  // byte address as seen by the lookup
  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [index_bits-1:0] index;
    logic [offset_bits-1:0] offset;
  } cache_addr_t;

  // word 0 sits in the low 64 bits
  typedef logic [beats_per_line-1:0][63:0] line_t;

  // state kept per line next to its tag
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [tag_bits-1:0] tag;
  } tag_entry_t;

  typedef logic [1:0] way_sel_t;

endpackage

`default_nettype wire

//--- hw/cache_top.sv
//####################################################################
// cache_top: L1 data cache, controller, tag and data arrays
// load/store aligner and memory bus master
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input wire clk,
  input wire reset,
  input wire access,
  input wire write,
  input wire cache_pkg::cache_addr_t address,
  input wire bus_pkg::mem_word_t value,
  input wire bus_pkg::mem_op_t mem_type,
  output bus_pkg::mem_word_t response,
  output logic busy,
  output logic finished,
  output logic bus_reqcyc,
  input wire bus_reqack,
  output logic [bus_pkg::bus_data_width-1:0] bus_req,
  output logic [bus_pkg::bus_tag_width-1:0] bus_reqtag,
  input wire bus_respcyc,
  output logic bus_respack,
  input wire [bus_pkg::bus_data_width-1:0] bus_resp,
  input wire [bus_pkg::bus_tag_width-1:0] bus_resptag
);

  cache_pkg::tag_entry_t [cache_pkg::ways-1:0] tag_rd;
  cache_pkg::line_t [cache_pkg::ways-1:0] data_rd;
  cache_pkg::tag_entry_t tag_wr_entry;
  cache_pkg::way_sel_t wr_way;
  cache_pkg::cache_addr_t wb_addr;
  cache_pkg::line_t refill_line;
  cache_pkg::line_t merged_line;
  cache_pkg::line_t align_line;
  cache_pkg::line_t data_wr_line;
  logic tag_wr_en;
  logic data_wr_en;
  logic data_sel_merge;
  logic fetch_start;
  logic wb_start;
  logic refill_done;
  logic writeback_done;

  // hit or held way normally, refill buffer while the line is installed
  assign align_line = data_sel_merge ? data_rd[wr_way] : refill_line;
  assign data_wr_line = data_sel_merge ? merged_line : refill_line;

  cache_ctrl u_ctrl (
    .clk(clk), .reset(reset), .access(access), .write(write),
    .address(address), .mem_type(mem_type), .tag_rd(tag_rd),
    .tag_wr_en(tag_wr_en), .data_wr_en(data_wr_en), .wr_way(wr_way),
    .tag_wr_entry(tag_wr_entry), .data_sel_merge(data_sel_merge),
    .fetch_start(fetch_start), .wb_start(wb_start), .wb_addr(wb_addr),
    .refill_done(refill_done), .writeback_done(writeback_done),
    .busy(busy), .finished(finished)
  );

  way_store #(.entry_t(cache_pkg::tag_entry_t)) u_tags (
    .clk(clk), .reset(reset), .index(address.index), .rd_entries(tag_rd),
    .wr_en(tag_wr_en), .wr_way(wr_way), .wr_entry(tag_wr_entry)
  );

  way_store #(.entry_t(cache_pkg::line_t)) u_data (
    .clk(clk), .reset(reset), .index(address.index), .rd_entries(data_rd),
    .wr_en(data_wr_en), .wr_way(wr_way), .wr_entry(data_wr_line)
  );

  load_store_align u_align (
    .line(align_line), .offset(address.offset), .mem_type(mem_type),
    .store_data(value), .load_value(response), .merged_line(merged_line)
  );

  // victim line is read from the held way during write-back beats
  bus_master u_bus (
    .clk(clk), .reset(reset),
    .fetch_start(fetch_start), .fetch_addr(address),
    .wb_start(wb_start), .wb_addr(wb_addr), .wb_line(data_rd[wr_way]),
    .refill_line(refill_line), .refill_done(refill_done),
    .writeback_done(writeback_done),
    .bus_reqcyc(bus_reqcyc), .bus_reqack(bus_reqack),
    .bus_req(bus_req), .bus_reqtag(bus_reqtag),
    .bus_respcyc(bus_respcyc), .bus_respack(bus_respack),
    .bus_resp(bus_resp), .bus_resptag(bus_resptag)
  );

endmodule

`default_nettype wire

//--- hw/load_store_align.sv
//####################################################################
// load_store_align: load field extraction with sign/zero extend
// and store data merge into a copy of the line
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module load_store_align (
  input wire cache_pkg::line_t line,
  input wire [cache_pkg::offset_bits-1:0] offset,
  input wire bus_pkg::mem_op_t mem_type,
  input wire bus_pkg::mem_word_t store_data,
  output bus_pkg::mem_word_t load_value,
  output cache_pkg::line_t merged_line
);

  logic [2:0] dword_sel;
  logic [5:0] bit_shift;
  bus_pkg::mem_word_t dword;
  bus_pkg::mem_word_t field;
  bus_pkg::mem_word_t store_mask;
  bus_pkg::mem_word_t lane_mask;
  bus_pkg::mem_word_t lane_data;

  // upper offset bits pick the 64-bit word
  assign dword_sel = offset[5:3];
  // low bits give the byte lane, accesses are naturally aligned
  assign bit_shift = {offset[2:0], 3'b000};
  assign dword = line[dword_sel];
  // requested field lands at bit 0
  assign field = dword >> bit_shift;

  always_comb begin
    case (mem_type)
      bus_pkg::lw: load_value = {{32{field[31]}}, field[31:0]};
      bus_pkg::lh: load_value = {{48{field[15]}}, field[15:0]};
      bus_pkg::lb: load_value = {{56{field[7]}}, field[7:0]};
      bus_pkg::lwu: load_value = {32'b0, field[31:0]};
      bus_pkg::lhu: load_value = {48'b0, field[15:0]};
      // byte-wide, not half-wide
      bus_pkg::lbu: load_value = {56'b0, field[7:0]};
      default: load_value = dword;
    endcase
  end

  // bytes touched by the store, before shifting into its lane
  always_comb begin
    case (mem_type)
      bus_pkg::sd: store_mask = '1;
      bus_pkg::sw: store_mask = 64'h0000_0000_ffff_ffff;
      bus_pkg::sh: store_mask = 64'h0000_0000_0000_ffff;
      bus_pkg::sb: store_mask = 64'h0000_0000_0000_00ff;
      // loads leave the line untouched
      default: store_mask = '0;
    endcase
  end

  assign lane_mask = store_mask << bit_shift;
  assign lane_data = (store_data & store_mask) << bit_shift;

  always_comb begin
    merged_line = line;
    merged_line[dword_sel] = (dword & ~lane_mask) | lane_data;
  end

endmodule

`default_nettype wire

//--- hw/way_store.sv
//####################################################################
// way_store: ways x sets storage array, one entry per line
// all ways of a set read at once, one way written per clock
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module way_store #(
  parameter type entry_t = cache_pkg::tag_entry_t
) (
  input wire clk,
  input wire reset,
  input wire [cache_pkg::index_bits-1:0] index,
  output entry_t [cache_pkg::ways-1:0] rd_entries,
  input wire wr_en,
  input wire cache_pkg::way_sel_t wr_way,
  input wire entry_t wr_entry
);

  entry_t mem [cache_pkg::ways][cache_pkg::sets];

  // reset leaves every valid bit clear
  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int w = 0; w < cache_pkg::ways; w++) begin
        for (int s = 0; s < cache_pkg::sets; s++) begin
          mem[w][s] <= '0;
        end
      end
    end else if (wr_en) begin
      mem[wr_way][index] <= wr_entry;
    end
  end

  // whole set out, the caller picks the way
  always_comb begin
    for (int w = 0; w < cache_pkg::ways; w++) begin
      rd_entries[w] = mem[w][index];
    end
  end

  wr_en_known: assert property (
    @(posedge clk) disable iff (!reset) !$isunknown(wr_en)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the cache regression with Verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module cache_tb -o cache_sim

./obj_dir/cache_sim | tee sim.log

# the exit status of the script comes from this search
grep -q "Regression passed" sim.log

//--- tb.f
hw/cache_pkg.sv
hw/bus_pkg.sv
hw/way_store.sv
hw/load_store_align.sv
hw/bus_master.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/mem_model.sv
test/cache_tb.sv

//--- test/cache_tb.sv
//####################################################################
// cache_tb: clock, reset, timeout, backing memory and LFSR stimulus
// directed tests against a reference memory, compare tasks
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  // ops per test: 2 + 29 + 8 + 10 + 200
  localparam int total_ops = 249;
  localparam int cycle_limit = total_ops * 40 + 200;
  localparam bus_pkg::mem_word_t fill_pattern = 64'h5a5a_0000_c3c3_0000;

  logic clk;
  logic reset;
  logic access;
  logic write;
  cache_pkg::cache_addr_t address;
  bus_pkg::mem_word_t value;
  bus_pkg::mem_op_t mem_type;
  bus_pkg::mem_word_t response;
  logic busy;
  logic finished;
  logic bus_reqcyc;
  logic bus_reqack;
  logic [bus_pkg::bus_data_width-1:0] bus_req;
  logic [bus_pkg::bus_tag_width-1:0] bus_reqtag;
  logic bus_respcyc;
  logic bus_respack;
  logic [bus_pkg::bus_data_width-1:0] bus_resp;
  logic [bus_pkg::bus_tag_width-1:0] bus_resptag;
  int wb_count;
  logic [11:0] peek_addr;
  bus_pkg::mem_word_t peek_data;
  logic peek_written;

  // expected memory contents, by word address
  bus_pkg::mem_word_t ref_mem [4096];
  logic [63:0] lfsr_state;
  int cycle_count;
  int req_count;
  int checks;
  int errors;

  cache_top UUT (
    .clk(clk), .reset(reset), .access(access), .write(write), .address(address),
    .value(value), .mem_type(mem_type), .response(response), .busy(busy),
    .finished(finished), .bus_reqcyc(bus_reqcyc), .bus_reqack(bus_reqack),
    .bus_req(bus_req), .bus_reqtag(bus_reqtag), .bus_respcyc(bus_respcyc),
    .bus_respack(bus_respack), .bus_resp(bus_resp), .bus_resptag(bus_resptag)
  );

  mem_model backing (
    .clk(clk), .reset(reset), .bus_reqcyc(bus_reqcyc), .bus_reqack(bus_reqack),
    .bus_req(bus_req), .bus_reqtag(bus_reqtag), .bus_respcyc(bus_respcyc),
    .bus_respack(bus_respack), .bus_resp(bus_resp), .bus_resptag(bus_resptag),
    .wb_count(wb_count), .peek_addr(peek_addr), .peek_data(peek_data),
    .peek_written(peek_written)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // accepted requests, reads and write-backs alike
  always @(posedge clk) begin
    if (!reset) begin
      req_count <= 0;
    end else if (bus_reqcyc && bus_reqack) begin
      req_count <= req_count + 1;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run still going after %0d cycles", cycle_limit);
    $display("Regression failed");
    $finish;
  end

  // x^64 + x^63 + x^61 + x^60 + 1, one step per bit taken
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] bits;
    logic fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[63] ^ lfsr_state[62] ^ lfsr_state[60] ^ lfsr_state[59];
      lfsr_state = {lfsr_state[62:0], fb};
      bits = {bits[62:0], fb};
    end
    return bits;
  endfunction

  function automatic int op_bytes(input bus_pkg::mem_op_t op);
    case (op)
      bus_pkg::ld, bus_pkg::sd: return 8;
      bus_pkg::lw, bus_pkg::lwu, bus_pkg::sw: return 4;
      bus_pkg::lh, bus_pkg::lhu, bus_pkg::sh: return 2;
      default: return 1;
    endcase
  endfunction

  // field at the byte offset, sign or zero fill above it
  function automatic bus_pkg::mem_word_t expect_load(input bus_pkg::mem_op_t op,
      input bus_pkg::mem_word_t word, input logic [2:0] off);
    int nbits;
    bus_pkg::mem_word_t mask;
    bus_pkg::mem_word_t field;
    nbits = 8 * op_bytes(op);
    mask = (nbits == 64) ? '1 : (64'd1 << nbits) - 64'd1;
    field = (word >> (8 * off)) & mask;
    if (op inside {bus_pkg::ld, bus_pkg::lw, bus_pkg::lh, bus_pkg::lb} && field[nbits-1]) begin
      field = field | ~mask;
    end
    return field;
  endfunction

  task automatic check_word(input string name, input bus_pkg::mem_word_t got,
      input bus_pkg::mem_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  // one access, held until finished; cycles counts edges after the drive
  task automatic run_op(input logic is_store, input bus_pkg::mem_op_t op,
      input logic [63:0] addr, input bus_pkg::mem_word_t data,
      output bus_pkg::mem_word_t result, output int cycles);
    @(posedge clk);
    access <= 1'b1;
    write <= is_store;
    address <= addr;
    value <= data;
    mem_type <= op;
    cycles = 0;
    @(negedge clk);
    while (!finished) begin
      // busy follows access until the finishing cycle
      check_bit("busy", busy, 1'b1);
      @(negedge clk);
      cycles++;
    end
    check_bit("busy", busy, 1'b0);
    result = response;
    @(posedge clk);
    access <= 1'b0;
    write <= 1'b0;
  endtask

  task automatic load_and_check(input bus_pkg::mem_op_t op, input logic [63:0] addr,
      output int cycles);
    bus_pkg::mem_word_t got;
    run_op(1'b0, op, addr, '0, got, cycles);
    check_word("response", got, expect_load(op, ref_mem[addr[14:3]], addr[2:0]));
  endtask

  task automatic store_and_track(input bus_pkg::mem_op_t op, input logic [63:0] addr,
      input bus_pkg::mem_word_t data);
    bus_pkg::mem_word_t got;
    int cycles;
    run_op(1'b1, op, addr, data, got, cycles);
    // low bytes of the store data land at the offset
    for (int b = 0; b < op_bytes(op); b++) begin
      ref_mem[addr[14:3]][8 * (addr[2:0] + b) +: 8] = data[8 * b +: 8];
    end
  endtask

  task automatic reset_values();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_bit("finished", finished, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("bus_reqcyc", bus_reqcyc, 1'b0);
    check_bit("bus_respack", bus_respack, 1'b0);
    report_test("reset values", e0);
  endtask

  task automatic miss_then_hit();
    int e0;
    int reqs;
    int cycles;
    e0 = errors;
    // set 2, tag 1
    load_and_check(bus_pkg::ld, 64'h880, cycles);
    reqs = req_count;
    load_and_check(bus_pkg::ld, 64'h880, cycles);
    check_count("hit latency", cycles, 2);
    check_count("bus requests on hit", req_count - reqs, 0);
    report_test("miss then hit", e0);
  endtask

  task automatic load_kinds();
    int e0;
    int cycles;
    bus_pkg::mem_op_t op;
    e0 = errors;
    // word 5a5a_0000_c3c3_0110 has both signs at every size
    for (int k = 0; k < 7; k++) begin
      op = bus_pkg::mem_op_t'(4'(k));
      for (int off = 0; off < 8; off += op_bytes(op)) begin
        load_and_check(op, 64'h880 + 64'(off), cycles);
      end
    end
    report_test("load kinds", e0);
  endtask

  task automatic store_kinds();
    int e0;
    int cycles;
    e0 = errors;
    // junk above each store size must not reach the line
    store_and_track(bus_pkg::sd, 64'h888, 64'h0123_4567_89ab_cdef);
    load_and_check(bus_pkg::ld, 64'h888, cycles);
    store_and_track(bus_pkg::sw, 64'h894, 64'hffff_ffff_8765_4321);
    load_and_check(bus_pkg::ld, 64'h890, cycles);
    store_and_track(bus_pkg::sh, 64'h89a, 64'h1111_2222_3333_beef);
    load_and_check(bus_pkg::ld, 64'h898, cycles);
    store_and_track(bus_pkg::sb, 64'h8a7, 64'h7777_0000_0000_00a5);
    load_and_check(bus_pkg::ld, 64'h8a0, cycles);
    report_test("store kinds", e0);
  endtask

  task automatic dirty_evictions();
    int e0;
    int cycles;
    int wb0;
    int lines_out;
    logic [11:0] base;
    e0 = errors;
    wb0 = wb_count;
    // five tags in set 7, one more than the ways
    for (int t = 1; t <= 5; t++) begin
      store_and_track(bus_pkg::sd, (64'(t) << 11) | (64'd7 << 6) | (64'(t) << 3),
                      lfsr_bits(64));
    end
    for (int t = 1; t <= 5; t++) begin
      load_and_check(bus_pkg::ld, (64'(t) << 11) | (64'd7 << 6) | (64'(t) << 3), cycles);
    end
    lines_out = 0;
    for (int t = 1; t <= 5; t++) begin
      base = 12'((t << 8) | (7 << 3));
      peek_addr = base;
      #1;
      if (peek_written) begin
        lines_out++;
        for (int w = 0; w < 8; w++) begin
          peek_addr = base | 12'(w);
          #1;
          check_word("written-back word", peek_data, ref_mem[peek_addr]);
        end
      end
    end
    check_count("write-backs", wb_count - wb0, lines_out);
    check_bit("any write-back", wb_count > wb0, 1'b1);
    report_test("dirty evictions", e0);
  endtask

  task automatic random_traffic();
    int e0;
    int cycles;
    logic is_store;
    logic [3:0] line;
    logic [2:0] sel;
    logic [2:0] word;
    logic [2:0] off;
    bus_pkg::mem_op_t op;
    logic [63:0] addr;
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      is_store = 1'(lfsr_bits(1));
      line = 4'(lfsr_bits(4));
      sel = 3'(lfsr_bits(is_store ? 2 : 3));
      if (is_store) begin
        op = bus_pkg::mem_op_t'(4'(bus_pkg::sd) + 4'(sel[1:0]));
      end else if (sel == 3'd7) begin
        op = bus_pkg::ld;
      end else begin
        op = bus_pkg::mem_op_t'(4'(sel));
      end
      word = 3'(lfsr_bits(3));
      // natural alignment for the access size
      off = 3'(lfsr_bits(3)) & 3'(~(op_bytes(op) - 1));
      // eight tags in each of sets 12 and 13
      addr = (64'(line[3:1]) << 11) | (64'(5'd12 + 5'(line[0])) << 6) | {58'd0, word, off};
      if (is_store) begin
        store_and_track(op, addr, lfsr_bits(64));
      end else begin
        load_and_check(op, addr, cycles);
      end
    end
    report_test("random traffic", e0);
  endtask

  initial begin
    lfsr_state = 64'd91;
    checks = 0;
    errors = 0;
    peek_addr = '0;
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = 64'(i) ^ fill_pattern;
    end
    reset = 1'b0;
    access = 1'b0;
    write = 1'b0;
    address = '0;
    value = '0;
    mem_type = bus_pkg::ld;
    repeat (5) @(posedge clk);
    reset <= 1'b1;
    reset_values();
    miss_then_hit();
    load_kinds();
    store_kinds();
    dirty_evictions();
    random_traffic();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/mem_model.sv
//####################################################################
// mem_model: behavioral backing memory on the cache bus
// answers line reads, takes write-back beats, counts write-backs
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input wire clk,
  input wire reset,
  input wire bus_reqcyc,
  output logic bus_reqack,
  input wire [bus_pkg::bus_data_width-1:0] bus_req,
  input wire [bus_pkg::bus_tag_width-1:0] bus_reqtag,
  output logic bus_respcyc,
  input wire bus_respack,
  output logic [bus_pkg::bus_data_width-1:0] bus_resp,
  output logic [bus_pkg::bus_tag_width-1:0] bus_resptag,
  output int wb_count,
  input wire [11:0] peek_addr,
  output bus_pkg::mem_word_t peek_data,
  output logic peek_written
);

  // 32 KB modelled, indexed by word address, higher bits alias
  bus_pkg::mem_word_t words [4096];
  logic written [4096];
  logic [8:0] line_base;
  logic [2:0] wr_beat;
  logic [3:0] wr_left;
  logic [2:0] rd_beat;
  logic reading;

  // untouched words hold their word address xor a fixed pattern
  initial begin
    for (int i = 0; i < 4096; i++) begin
      words[i] = 64'(i) ^ 64'h5a5a_0000_c3c3_0000;
      written[i] = 1'b0;
    end
  end

  assign peek_data = words[peek_addr];
  assign peek_written = written[peek_addr];

  always @(posedge clk) begin
    if (!reset) begin
      bus_reqack <= 1'b0;
      bus_respcyc <= 1'b0;
      bus_resp <= '0;
      bus_resptag <= bus_pkg::mem_read_tag;
      wr_left <= '0;
      reading <= 1'b0;
      wb_count <= 0;
    end else begin
      // ack each request for exactly one cycle
      bus_reqack <= bus_reqcyc && !bus_reqack;
      if (bus_reqcyc && bus_reqack) begin
        line_base <= bus_req[14:6];
        if (bus_reqtag == bus_pkg::mem_write_tag) begin
          wr_left <= 4'd8;
          wr_beat <= 3'd0;
          wb_count <= wb_count + 1;
        end else begin
          reading <= 1'b1;
          rd_beat <= 3'd0;
          bus_respcyc <= 1'b1;
          bus_resp <= words[{bus_req[14:6], 3'd0}];
        end
      end else if (wr_left != 4'd0) begin
        // data beats follow the header, no handshake
        words[{line_base, wr_beat}] <= bus_req;
        written[{line_base, wr_beat}] <= 1'b1;
        wr_beat <= wr_beat + 3'd1;
        wr_left <= wr_left - 4'd1;
      end
      // next beat only after the cache acked this one
      if (reading && bus_respack) begin
        if (rd_beat == 3'd7) begin
          reading <= 1'b0;
          bus_respcyc <= 1'b0;
        end else begin
          rd_beat <= rd_beat + 3'd1;
          bus_resp <= words[{line_base, rd_beat + 3'd1}];
        end
      end
    end
  end

endmodule

`default_nettype wire
